//--- design/matmul_pkg.sv
package matmul_pkg;

  // element and array geometry
  localparam int elem_width = 16;
  localparam int lanes = 4;
  localparam int acc_width = 32;
  localparam int addr_width = 7;

  // skew plus ripple through the grid for the last fed column,
  // memory read latency not included
  localparam int settle_cycles = 2 * (lanes - 1);

  typedef logic [elem_width-1:0] elem_t;

  // lane 0 sits in the low bits
  typedef logic [lanes-1:0][elem_width-1:0] row_t;

  typedef logic [addr_width-1:0] addr_t;

  typedef logic [acc_width-1:0] acc_t;

  typedef enum logic [1:0] {
    st_idle,
    st_feed,
    st_settle,
    st_drain
  } ctrl_state_t;

endpackage

//--- design/row_ram.sv
`timescale 1ns/1ps

module row_ram
  import matmul_pkg::*;
#(
  parameter int mem_depth = 128
) (
  input  logic  clk,
  input  logic  we,
  input  addr_t addr,
  input  row_t  wdata,
  output row_t  rdata
);

  row_t mem [mem_depth];

  // read returns the old word on a collision
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];
  end

endmodule

//--- design/operand_skew.sv
`timescale 1ns/1ps

module operand_skew
  import matmul_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic clear,
  input  row_t row_in,
  output row_t lanes_out
);

  genvar i;

  generate
    for (i = 0; i < lanes; i++) begin : g_lane
      if (i == 0) begin : g_direct
        // lane 0 leads the wavefront
        assign lanes_out[0] = row_in[0];
      end else begin : g_delay
        elem_t taps [i];

        always_ff @(posedge clk) begin
          if (reset || clear) begin
            for (int k = 0; k < i; k++) begin
              taps[k] <= '0;
            end
          end else begin
            taps[0] <= row_in[i];
            for (int k = 1; k < i; k++) begin
              taps[k] <= taps[k-1];
            end
          end
        end

        // i stages deep
        assign lanes_out[i] = taps[i-1];
      end
    end
  endgenerate

endmodule

//--- design/processing_element.sv
`timescale 1ns/1ps

module processing_element
  import matmul_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  clear,
  input  elem_t in_a,
  input  elem_t in_b,
  output elem_t out_a,
  output elem_t out_b,
  output elem_t out_c
);

  acc_t              acc;
  acc_t              product;
  logic [acc_width:0] sum;

  assign product = acc_t'(in_a) * acc_t'(in_b);
  assign sum     = {1'b0, acc} + {1'b0, product};

  // operands move one cell right and one cell down per cycle
  always_ff @(posedge clk) begin
    if (reset || clear) begin
      out_a <= '0;
      out_b <= '0;
    end else begin
      out_a <= in_a;
      out_b <= in_b;
    end
  end

  // accumulator sticks at all ones once it overflows
  always_ff @(posedge clk) begin
    if (reset || clear) begin
      acc <= '0;
    end else if (sum[acc_width]) begin
      acc <= '1;
    end else begin
      acc <= sum[acc_width-1:0];
    end
  end

  // saturate to 16 bits
  assign out_c = (|acc[acc_width-1:elem_width]) ? '1 : acc[elem_width-1:0];

endmodule

//--- design/systolic_array_4x4.sv
`timescale 1ns/1ps

module systolic_array_4x4
  import matmul_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       clear,
  input  row_t       a_lanes,
  input  row_t       b_lanes,
  input  logic [1:0] row_sel,
  output row_t       row_data
);

  // horizontal links carry A, vertical links carry B
  elem_t a_link [lanes][lanes+1];
  elem_t b_link [lanes+1][lanes];
  row_t  c_rows [lanes];

  genvar i;
  genvar j;

  generate
    for (i = 0; i < lanes; i++) begin : g_edge
      // A enters on the left, B on the top
      assign a_link[i][0] = a_lanes[i];
      assign b_link[0][i] = b_lanes[i];
    end

    for (i = 0; i < lanes; i++) begin : g_row
      for (j = 0; j < lanes; j++) begin : g_col
        processing_element pe (
          .clk   (clk),
          .reset (reset),
          .clear (clear),
          .in_a  (a_link[i][j]),
          .in_b  (b_link[i][j]),
          .out_a (a_link[i][j+1]),
          .out_b (b_link[i+1][j]),
          .out_c (c_rows[i][j])
        );
      end
    end
  endgenerate

  // one result row at a time for the C write
  assign row_data = c_rows[row_sel];

endmodule

//--- design/matmul_controller.sv
`timescale 1ns/1ps

module matmul_controller
  import matmul_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       start,
  output logic       busy,
  output logic       done,
  output logic       clear,
  output addr_t      feed_addr,
  output logic [1:0] row_sel,
  output logic       c_we,
  output addr_t      c_addr
);

  ctrl_state_t state;
  addr_t       step;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      step  <= '0;
      busy  <= 1'b0;
      done  <= 1'b0;
      clear <= 1'b0;
    end else begin
      done  <= 1'b0;
      clear <= 1'b0;
      case (state)
        st_idle: begin
          if (start) begin
            state <= st_feed;
            step  <= '0;
            busy  <= 1'b1;
            // wipes the grid and skew lines during the first feed cycle
            clear <= 1'b1;
          end
        end
        st_feed: begin
          if (step == addr_t'(lanes - 1)) begin
            state <= st_settle;
            step  <= '0;
          end else begin
            step <= step + 1'b1;
          end
        end
        st_settle: begin
          // one extra cycle for the memory read
          if (step == addr_t'(settle_cycles)) begin
            state <= st_drain;
            step  <= '0;
          end else begin
            step <= step + 1'b1;
          end
        end
        st_drain: begin
          if (step == addr_t'(lanes - 1)) begin
            state <= st_idle;
            step  <= '0;
            busy  <= 1'b0;
            done  <= 1'b1;
          end else begin
            step <= step + 1'b1;
          end
        end
        default: begin
          state <= st_idle;
          step  <= '0;
          busy  <= 1'b0;
        end
      endcase
    end
  end

  // out of range when not feeding, so the top masks the operands
  assign feed_addr = (state == st_feed) ? step : addr_t'(lanes);

  // row i of the grid lands at C address i
  assign row_sel = step[1:0];
  assign c_we    = (state == st_drain);
  assign c_addr  = step;

endmodule

//--- design/matmul_top.sv
`timescale 1ns/1ps

module matmul_top
  import matmul_pkg::*;
#(
  parameter int mem_depth = 128
) (
  input  logic  clk,
  input  logic  reset,
  input  logic  load_a,
  input  logic  load_b,
  input  logic  start,
  input  logic  read,
  input  addr_t load_addr,
  input  addr_t read_addr,
  input  row_t  load_data,
  output row_t  read_data,
  output logic  read_valid,
  output logic  done,
  output logic  busy
);

  logic       run_start;
  logic       clear;
  logic       feed_q;
  logic       c_we;
  logic [1:0] row_sel;
  addr_t      feed_addr;
  addr_t      c_addr;
  addr_t      a_addr;
  addr_t      b_addr;
  addr_t      c_mem_addr;
  row_t       a_rdata;
  row_t       b_rdata;
  row_t       a_feed;
  row_t       b_feed;
  row_t       a_skewed;
  row_t       b_skewed;
  row_t       row_data;

  // host strobes are dropped while a run is in flight
  assign run_start = start & ~busy;

  // engine owns the memory ports while busy
  assign a_addr     = busy ? feed_addr : load_addr;
  assign b_addr     = busy ? feed_addr : load_addr;
  assign c_mem_addr = busy ? c_addr : read_addr;

  row_ram #(
    .mem_depth (mem_depth)
  ) mem_a (
    .clk   (clk),
    .we    (load_a & ~busy),
    .addr  (a_addr),
    .wdata (load_data),
    .rdata (a_rdata)
  );

  row_ram #(
    .mem_depth (mem_depth)
  ) mem_b (
    .clk   (clk),
    .we    (load_b & ~busy),
    .addr  (b_addr),
    .wdata (load_data),
    .rdata (b_rdata)
  );

  row_ram #(
    .mem_depth (mem_depth)
  ) mem_c (
    .clk   (clk),
    .we    (c_we),
    .addr  (c_mem_addr),
    .wdata (row_data),
    .rdata (read_data)
  );

  // tracks the read latency, zeros reach the grid outside the feed window
  always_ff @(posedge clk) begin
    if (reset) begin
      feed_q <= 1'b0;
    end else begin
      feed_q <= (feed_addr < addr_t'(lanes));
    end
  end

  assign a_feed = feed_q ? a_rdata : '0;
  assign b_feed = feed_q ? b_rdata : '0;

  operand_skew skew_a (
    .clk       (clk),
    .reset     (reset),
    .clear     (clear),
    .row_in    (a_feed),
    .lanes_out (a_skewed)
  );

  operand_skew skew_b (
    .clk       (clk),
    .reset     (reset),
    .clear     (clear),
    .row_in    (b_feed),
    .lanes_out (b_skewed)
  );

  systolic_array_4x4 array (
    .clk      (clk),
    .reset    (reset),
    .clear    (clear),
    .a_lanes  (a_skewed),
    .b_lanes  (b_skewed),
    .row_sel  (row_sel),
    .row_data (row_data)
  );

  matmul_controller ctrl (
    .clk       (clk),
    .reset     (reset),
    .start     (run_start),
    .busy      (busy),
    .done      (done),
    .clear     (clear),
    .feed_addr (feed_addr),
    .row_sel   (row_sel),
    .c_we      (c_we),
    .c_addr    (c_addr)
  );

  // C row shows up one cycle after the strobe
  always_ff @(posedge clk) begin
    if (reset) begin
      read_valid <= 1'b0;
    end else begin
      read_valid <= read & ~busy;
    end
  end

endmodule

//--- testbench/matmul_tb.sv
`timescale 1ns/1ps

module matmul_tb
  import matmul_pkg::*;
();

  localparam int n_table = 3;
  localparam int n_random = 6;
  localparam int n_cases = n_table + n_random;
  localparam int run_limit = 64;
  // load/read plus run cycles per case at 4 ns, doubled
  localparam int watchdog_ns = n_cases * (16 + 64) * 4 * 2;

  logic  clk;
  logic  reset;
  logic  load_a;
  logic  load_b;
  logic  start;
  logic  read;
  addr_t load_addr;
  addr_t read_addr;
  row_t  load_data;
  row_t  read_data;
  logic  read_valid;
  logic  done;
  logic  busy;

  integer seed;

  // matrices of the case in progress, indexed [row][col]
  elem_t cur_a [lanes][lanes];
  elem_t cur_b [lanes][lanes];
  elem_t exp_c [lanes][lanes];

  // identity, small products, one saturating sum
  elem_t tbl_a [n_table][lanes][lanes] = '{
    '{'{1, 0, 0, 0}, '{0, 1, 0, 0}, '{0, 0, 1, 0}, '{0, 0, 0, 1}},
    '{'{1, 2, 3, 4}, '{5, 6, 7, 8}, '{9, 10, 11, 12}, '{13, 14, 15, 16}},
    '{'{300, 2, 0, 0}, '{0, 1, 0, 0}, '{0, 0, 1, 0}, '{0, 0, 0, 1}}
  };
  elem_t tbl_b [n_table][lanes][lanes] = '{
    '{'{16'hffff, 16'h8000, 16'h0001, 16'h1234}, '{16'h00ff, 16'hbeef, 16'h0000, 16'h7fff},
      '{16'h0f0f, 16'h4321, 16'hcafe, 16'h0002}, '{16'h0010, 16'h0100, 16'h1000, 16'habcd}},
    '{'{1, 0, 2, 1}, '{0, 1, 1, 2}, '{3, 1, 0, 1}, '{2, 2, 1, 0}},
    '{'{300, 5, 0, 7}, '{10, 20, 30, 40}, '{1, 2, 3, 4}, '{5, 6, 7, 8}}
  };
  elem_t tbl_c [n_table][lanes][lanes] = '{
    '{'{16'hffff, 16'h8000, 16'h0001, 16'h1234}, '{16'h00ff, 16'hbeef, 16'h0000, 16'h7fff},
      '{16'h0f0f, 16'h4321, 16'hcafe, 16'h0002}, '{16'h0010, 16'h0100, 16'h1000, 16'habcd}},
    '{'{18, 13, 8, 8}, '{42, 29, 24, 24}, '{66, 45, 40, 40}, '{90, 61, 56, 56}},
    '{'{16'hffff, 1540, 60, 2180}, '{10, 20, 30, 40}, '{1, 2, 3, 4}, '{5, 6, 7, 8}}
  };

  matmul_top #(
    .mem_depth (128)
  ) dut_i (
    .clk        (clk),
    .reset      (reset),
    .load_a     (load_a),
    .load_b     (load_b),
    .start      (start),
    .read       (read),
    .load_addr  (load_addr),
    .read_addr  (read_addr),
    .load_data  (load_data),
    .read_data  (read_data),
    .read_valid (read_valid),
    .done       (done),
    .busy       (busy)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    #(watchdog_ns);
    $display("Timeout at %0t ns: the test did not finish within %0d ns", $time, watchdog_ns);
    $display("FAIL: see errors above");
    $fatal(1, "watchdog expired");
  end

  // inputs change and outputs are sampled 1 ns after the edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check_row(input string name, input row_t actual, input row_t expected);
    if (actual !== expected) begin
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      $display("FAIL: see errors above");
      $fatal(1, "row mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("Mismatch at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
      $display("FAIL: see errors above");
      $fatal(1, "flag mismatch");
    end
  endtask

  // sum of products, clipped to all ones above 16 bits
  task automatic model_multiply();
    longint sum;
    for (int i = 0; i < lanes; i++) begin
      for (int j = 0; j < lanes; j++) begin
        sum = 0;
        for (int k = 0; k < lanes; k++) begin
          sum += longint'(cur_a[i][k]) * longint'(cur_b[k][j]);
        end
        exp_c[i][j] = (sum > 65535) ? 16'hffff : elem_t'(sum);
      end
    end
  endtask

  // A word k is column k, B word k is row k
  task automatic load_operands(input logic with_a);
    for (int k = 0; k < lanes && with_a; k++) begin
      for (int i = 0; i < lanes; i++) begin
        load_data[i] = cur_a[i][k];
      end
      load_a = 1'b1;
      load_addr = addr_t'(k);
      next_cycle();
    end
    load_a = 1'b0;
    for (int k = 0; k < lanes; k++) begin
      for (int j = 0; j < lanes; j++) begin
        load_data[j] = cur_b[k][j];
      end
      load_b = 1'b1;
      load_addr = addr_t'(k);
      next_cycle();
    end
    load_b = 1'b0;
  endtask

  task automatic run_and_wait(input logic interfere);
    int cycles;
    cycles = 0;
    start = 1'b1;
    next_cycle();
    start = 1'b0;
    check_flag("busy", busy, 1'b1);
    check_flag("done", done, 1'b0);
    if (interfere) begin
      // both strobes land while busy and must be dropped
      load_b = 1'b1;
      load_addr = '0;
      load_data = {lanes{16'h5a5a}};
      read = 1'b1;
      read_addr = '0;
      next_cycle();
      load_b = 1'b0;
      read = 1'b0;
      check_flag("read_valid", read_valid, 1'b0);
    end
    while (done !== 1'b1 && cycles < run_limit) begin
      next_cycle();
      cycles++;
    end
    if (done !== 1'b1) begin
      $display("Timeout at %0t ns: done did not pulse within %0d cycles", $time, run_limit);
      $display("FAIL: see errors above");
      $fatal(1, "run did not complete");
    end
    check_flag("busy", busy, 1'b0);
    next_cycle();
    check_flag("done", done, 1'b0);
  endtask

  task automatic read_and_check();
    row_t want;
    for (int r = 0; r < lanes; r++) begin
      for (int j = 0; j < lanes; j++) begin
        want[j] = exp_c[r][j];
      end
      read = 1'b1;
      read_addr = addr_t'(r);
      next_cycle();
      read = 1'b0;
      check_flag("read_valid", read_valid, 1'b1);
      check_row($sformatf("read_data[%0d]", r), read_data, want);
      next_cycle();
      check_flag("read_valid", read_valid, 1'b0);
    end
  endtask

  initial begin
    seed = 32'hdfe3f434;
    reset = 1'b1;
    load_a = 1'b0;
    load_b = 1'b0;
    start = 1'b0;
    read = 1'b0;
    load_addr = '0;
    read_addr = '0;
    load_data = '0;

    for (int c = 0; c < 18; c++) begin
      if (c == 16) begin
        reset = 1'b0;
      end
      next_cycle();
      check_flag("done", done, 1'b0);
      check_flag("busy", busy, 1'b0);
      check_flag("read_valid", read_valid, 1'b0);
    end

    // directed cases, each rerun without reloading
    for (int c = 0; c < n_table; c++) begin
      for (int i = 0; i < lanes; i++) begin
        for (int j = 0; j < lanes; j++) begin
          cur_a[i][j] = tbl_a[c][i][j];
          cur_b[i][j] = tbl_b[c][i][j];
          exp_c[i][j] = tbl_c[c][i][j];
        end
      end
      load_operands(1'b1);
      run_and_wait(1'b1);
      read_and_check();
      run_and_wait(1'b0);
      read_and_check();
    end

    // A stays loaded, a fresh B for every run
    for (int i = 0; i < lanes; i++) begin
      for (int j = 0; j < lanes; j++) begin
        cur_a[i][j] = elem_t'($random(seed) & 32'h00ff);
      end
    end
    for (int c = 0; c < n_random; c++) begin
      for (int i = 0; i < lanes; i++) begin
        for (int j = 0; j < lanes; j++) begin
          cur_b[i][j] = elem_t'($random(seed) & 32'h00ff);
        end
      end
      model_multiply();
      load_operands(c == 0);
      run_and_wait(1'b0);
      read_and_check();
    end

    $display("PASS: all tests");
    $finish;
  end

endmodule

//--- compile.f
design/matmul_pkg.sv
design/row_ram.sv
design/operand_skew.sv
design/processing_element.sv
design/systolic_array_4x4.sv
design/matmul_controller.sv
design/matmul_top.sv
testbench/matmul_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the matmul testbench with Verilator and run it
# the exit status of the simulation is the result of the test
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  -f compile.f \
  --top-module matmul_tb \
  -Mdir obj_dir \
  -o matmul_sim

./obj_dir/matmul_sim
